/* spi_regs_top.f */
common/spi_regs_pkg.sv
spi/sync_sig.sv
spi/spi_iff.sv
hdl/reg_bank.sv
hdl/cmd_ctrl.sv
hdl/spi_regs_top.sv
testbench/spi_regs_props.sv
testbench/tb_spi_regs.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_spi_regs
FILELIST  := spi_regs_top.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
PASS_MSG  := TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass line shows up in the output.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_spi_regs.sv */
`timescale 1ns/1ns

module tb_spi_regs;

    import spi_regs_pkg::*;

    localparam int REG_DEPTH = 16;
    localparam int AW        = $clog2(REG_DEPTH);

    logic clk;
    logic nrst;
    logic spi_clk;
    logic spi_ss;
    logic spi_mosi;
    logic spi_miso;

    logic [31:0] model_regs [REG_DEPTH];
    logic [31:0] model_cnt;  // Good frames seen by the model.
    spi_resp_t   model_resp; // Reply due in the next transfer.

    logic [47:0] got_q  [$];
    logic [47:0] exp_q  [$];
    logic [47:0] mask_q [$]; // Bits actually clocked out.
    int          err_cnt;
    int          fail_cnt;

    spi_regs_top #(
        .REG_DEPTH (REG_DEPTH)
    ) i_spi_regs_top (
        .clk      (clk),
        .nrst     (nrst),
        .spi_clk  (spi_clk),
        .spi_ss   (spi_ss),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    always #2 clk = ~clk;

    // Returns the reply due in this transfer, then applies the frame to the model.
    function automatic spi_resp_t model_frame(input logic [55:0] bits, input int nbits);
        spi_resp_t  due;
        spi_resp_t  nxt;
        spi_frame_t cap;
        due = model_resp;
        cap = '0;
        for (int i = nbits - 1; i >= 0; i--) begin
            cap = {cap[46:0], bits[i]}; // Last 48 bits stay captured.
        end
        if ((nbits % 8 == 0) && (nbits != 0)) begin
            nxt      = '0;
            nxt.addr = cap.addr;
            if (nbits != 8 * FRAME_BYTES) begin
                nxt.status[ST_LEN_ERR] = 1'b1;
            end else if (!(cap.opcode inside {OP_WRITE, OP_READ, OP_STATUS})) begin
                nxt.status[ST_OP_ERR] = 1'b1;
            end else if ((cap.opcode != OP_STATUS) && (int'(cap.addr) >= REG_DEPTH)) begin
                nxt.status[ST_ADDR_ERR] = 1'b1;
            end else begin
                nxt.status[ST_OK] = 1'b1;
                model_cnt = model_cnt + 32'd1;
                case (cap.opcode)
                    OP_WRITE: begin
                        model_regs[cap.addr[AW-1:0]] = cap.data;
                        nxt.data = cap.data;
                    end
                    OP_READ: nxt.data = model_regs[cap.addr[AW-1:0]];
                    default: nxt.data = model_cnt;
                endcase
            end
            model_resp = nxt;
        end
        return due;
    endfunction

    task automatic step_clocks(input int n);
        repeat (n) @(posedge clk);
        #1; // Pins change just after the edge.
    endtask

    // Mode 0 master, MSB first, samples MISO as SCK rises.
    task automatic spi_xfer(input logic [55:0] bits, input int nbits);
        logic [47:0] got;
        logic [47:0] mask;
        spi_resp_t   exp;
        int          n_rx;
        got    = '0;
        exp    = model_frame(bits, nbits);
        n_rx   = (nbits < 48) ? nbits : 48;
        spi_ss = 1'b0;
        for (int i = nbits - 1; i >= 0; i--) begin
            spi_mosi = bits[i];
            step_clocks(4);
            if (nbits - 1 - i < 48) begin
                got = {got[46:0], spi_miso};
            end
            spi_clk = 1'b1;
            step_clocks(4);
            spi_clk = 1'b0;
        end
        spi_mosi = 1'b0;
        step_clocks(4);
        spi_ss = 1'b1;
        step_clocks(10);
        got  = got << (48 - n_rx);
        mask = {48{1'b1}} << (48 - n_rx);
        got_q.push_back(got);
        exp_q.push_back(exp);
        mask_q.push_back(mask);
    endtask

    task automatic send_frame(input logic [7:0] op, input logic [7:0] addr,
                              input logic [31:0] data);
        spi_xfer({8'h00, op, addr, data}, 48);
    endtask

    always @(posedge clk) begin : compare
        logic [47:0] got;
        logic [47:0] exp;
        logic [47:0] mask;
        if (got_q.size() > 0) begin
            got  = got_q.pop_front() & mask_q[0];
            exp  = exp_q.pop_front() & mask_q[0];
            mask = mask_q.pop_front();
            assert (got == exp) else begin
                err_cnt++;
                $display("ERR %0t resp: got %h expected %h (mask %h)", $time, got, exp, mask);
            end
        end
    end

    task automatic report_and_finish;
        $display("Errors: %0d value mismatches, %0d other failures", err_cnt, fail_cnt);
        if ((err_cnt == 0) && (fail_cnt == 0)) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    initial begin
        logic [7:0]  addrs [8];
        logic [31:0] data;
        logic [7:0]  addr;
        int          kind;
        int          wait_cnt;
        clk        = 1'b0;
        nrst       = 1'b0;
        spi_clk    = 1'b0;
        spi_ss     = 1'b1;
        spi_mosi   = 1'b0;
        err_cnt    = 0;
        fail_cnt   = 0;
        model_cnt  = '0;
        model_resp = '0;
        for (int i = 0; i < REG_DEPTH; i++) begin
            model_regs[i] = '0;
        end
        void'($urandom(15546));
        step_clocks(5);
        nrst = 1'b1;
        step_clocks(2);

        // Writes, then reads of the same addresses. The first reply is all zero.
        for (int i = 0; i < 8; i++) begin
            addrs[i] = 8'($urandom % REG_DEPTH);
            send_frame(OP_WRITE, addrs[i], $urandom);
        end
        for (int i = 0; i < 8; i++) begin
            send_frame(OP_READ, addrs[i], '0);
        end
        send_frame(OP_STATUS, 8'h00, '0);

        // Bad lengths must not touch the bank.
        data = $urandom;
        spi_xfer({16'h0, OP_WRITE, addrs[0], data[23:0]}, 40);
        spi_xfer({OP_WRITE, addrs[1], data, 8'hA5}, 56);
        send_frame(OP_READ, addrs[0], '0);
        send_frame(OP_READ, addrs[1], '0);
        spi_xfer({8'h00, OP_WRITE, addrs[2], data}, 45); // Not byte aligned so the reply repeats.
        send_frame(OP_READ, addrs[2], '0);

        send_frame(8'h5A, addrs[3], data);
        send_frame(OP_WRITE, 8'(REG_DEPTH) + addrs[4], data);
        send_frame(OP_READ, addrs[4], '0);
        send_frame(OP_STATUS, 8'hFF, '0);

        for (int n = 0; n < 200; n++) begin
            kind = $urandom % 8;
            addr = 8'($urandom % (REG_DEPTH + 4));
            data = $urandom;
            case (kind)
                0, 1, 2: send_frame(OP_WRITE, addr, data);
                3, 4:    send_frame(OP_READ, addr, data);
                5:       send_frame(OP_STATUS, addr, data);
                6:       send_frame(8'h04 + 8'($urandom % 200), addr, data);
                default: spi_xfer({16'h0, OP_READ, addr, data[23:0]}, 40);
            endcase
        end
        send_frame(OP_STATUS, 8'h00, '0); // Flushes the last reply.

        wait_cnt = 0;
        while ((got_q.size() > 0) && (wait_cnt < 20)) begin
            @(posedge clk);
            wait_cnt++;
        end
        assert (got_q.size() == 0) else begin
            fail_cnt++;
            $display("Timeout: replies were still waiting to be compared");
        end
        report_and_finish();
    end

endmodule

/* testbench/spi_regs_props.sv */
`timescale 1ns/1ns

module spi_regs_props #(
    parameter int REG_DEPTH = 16
) (
    input logic                   clk,
    input logic                   nrst,
    input logic                   valid,
    input logic                   req_en,
    input spi_regs_pkg::reg_req_t reg_req
);

    // A bank access only follows an accepted frame.
    req_after_valid: assert property (@(posedge clk) disable iff (!nrst)
        req_en |-> $past(valid))
        else $error("req_en high without valid one cycle earlier");

    // Reply takes two more cycles after valid.
    no_overlap: assert property (@(posedge clk) disable iff (!nrst)
        valid |-> (!$past(valid) && !$past(valid, 2)))
        else $error("valid arrived while a reply was pending");

    addr_in_range: assert property (@(posedge clk) disable iff (!nrst)
        req_en |-> (32'(reg_req.addr) < REG_DEPTH))
        else $error("register access outside the bank");

endmodule

bind cmd_ctrl spi_regs_props #(
    .REG_DEPTH (REG_DEPTH)
) i_spi_regs_props (
    .clk     (clk),
    .nrst    (nrst),
    .valid   (valid),
    .req_en  (req_en),
    .reg_req (reg_req)
);

/* hdl/spi_regs_top.sv */
`timescale 1ns/1ns

module spi_regs_top #(
    parameter int REG_DEPTH = 16
) (
    input  logic clk,
    input  logic nrst,
    input  logic spi_clk,
    input  logic spi_ss,
    input  logic spi_mosi,
    output logic spi_miso
);

    import spi_regs_pkg::*;

    localparam int MOSI_SIZE = $bits(spi_frame_t); // 48 bits.
    localparam int MISO_SIZE = $bits(spi_resp_t);

    logic [MOSI_SIZE-1:0] data_mosi;
    logic [MISO_SIZE-1:0] data_miso;
    logic [10:0]          data_len_bytes;
    logic                 valid;
    spi_frame_t           frame;
    spi_resp_t            resp;
    logic                 req_en;
    reg_req_t             reg_req;
    logic [31:0]          rdata;

    assign frame     = spi_frame_t'(data_mosi);
    assign data_miso = resp;

    spi_iff #(
        .MOSI_SIZE (MOSI_SIZE),
        .MISO_SIZE (MISO_SIZE)
    ) i_spi_iff (
        .clk            (clk),
        .nrst           (nrst),
        .spi_clk        (spi_clk),
        .spi_ss         (spi_ss),
        .spi_mosi       (spi_mosi),
        .spi_miso       (spi_miso),
        .data_mosi      (data_mosi),
        .data_len_bytes (data_len_bytes),
        .data_miso      (data_miso),
        .valid          (valid)
    );

    cmd_ctrl #(
        .REG_DEPTH (REG_DEPTH)
    ) i_cmd_ctrl (
        .clk       (clk),
        .nrst      (nrst),
        .valid     (valid),
        .frame     (frame),
        .len_bytes (data_len_bytes),
        .req_en    (req_en),
        .reg_req   (reg_req),
        .rdata     (rdata),
        .resp      (resp)
    );

    reg_bank #(
        .REG_DEPTH (REG_DEPTH)
    ) i_reg_bank (
        .clk     (clk),
        .nrst    (nrst),
        .req_en  (req_en),
        .reg_req (reg_req),
        .rdata   (rdata)
    );

endmodule

/* hdl/cmd_ctrl.sv */
`timescale 1ns/1ns

module cmd_ctrl #(
    parameter int REG_DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     valid,
    input  spi_regs_pkg::spi_frame_t frame,
    input  logic [10:0]              len_bytes,
    output logic                     req_en,
    output spi_regs_pkg::reg_req_t   reg_req,
    input  logic [31:0]              rdata,
    output spi_regs_pkg::spi_resp_t  resp
);

    import spi_regs_pkg::*;

    typedef enum logic {
        S_IDLE,
        S_WAIT
    } state_t;

    state_t state;

    logic        is_access; // WRITE or READ.
    logic        op_known;
    logic [7:0]  status;
    logic        good;
    logic [31:0] reply_data;
    logic [31:0] frame_cnt;  // Good frames accepted so far.

    logic [7:0]  pend_status;
    logic [7:0]  pend_addr;
    logic [31:0] pend_data;
    logic        pend_read;  // Reply data comes from the bank.

    // Checks run in order and only the first failure is reported.
    always_comb begin
        is_access = (frame.opcode == OP_WRITE) || (frame.opcode == OP_READ);
        op_known  = is_access || (frame.opcode == OP_STATUS);
        status    = '0;
        if (len_bytes != 11'(FRAME_BYTES)) begin
            status[ST_LEN_ERR] = 1'b1;
        end else if (!op_known) begin
            status[ST_OP_ERR] = 1'b1;
        end else if (is_access && (32'(frame.addr) >= REG_DEPTH)) begin
            status[ST_ADDR_ERR] = 1'b1;
        end else begin
            status[ST_OK] = 1'b1;
        end
    end

    assign good = status[ST_OK];

    always_comb begin
        reply_data = '0; // Errors return zero.
        if (good) begin
            case (frame.opcode)
                OP_WRITE:  reply_data = frame.data;
                OP_STATUS: reply_data = frame_cnt + 32'd1; // Counts this frame too.
                default:   reply_data = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state     <= S_IDLE;
            req_en    <= 1'b0;
            frame_cnt <= '0;
            resp      <= '0;
        end else begin
            req_en <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (valid) begin
                        req_en <= good && is_access;
                        if (good) begin
                            frame_cnt <= frame_cnt + 32'd1;
                        end
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    // Reply is built once the bank access is done.
                    if (!req_en) begin
                        resp.status <= pend_status;
                        resp.addr   <= pend_addr;
                        resp.data   <= pend_read ? rdata : pend_data;
                        state       <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == S_IDLE) && valid) begin
            reg_req.we    <= (frame.opcode == OP_WRITE);
            reg_req.addr  <= frame.addr;
            reg_req.wdata <= frame.data;
            pend_status   <= status;
            pend_addr     <= frame.addr; // Echoed in the reply.
            pend_data     <= reply_data;
            pend_read     <= good && (frame.opcode == OP_READ);
        end
    end

endmodule

/* hdl/reg_bank.sv */
`timescale 1ns/1ns

module reg_bank #(
    parameter int REG_DEPTH = 16
) (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   req_en,
    input  spi_regs_pkg::reg_req_t reg_req,
    output logic [31:0]            rdata
);

    localparam int AW = (REG_DEPTH > 1) ? $clog2(REG_DEPTH) : 1;

    logic [31:0]   regs [REG_DEPTH];
    logic [AW-1:0] idx;

    // Low address bits select the register.
    assign idx = reg_req.addr[AW-1:0];

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < REG_DEPTH; i++) begin
                regs[i] <= '0;
            end
            rdata <= '0;
        end else if (req_en) begin
            if (reg_req.we) begin
                regs[idx] <= reg_req.wdata;
            end else begin
                rdata <= regs[idx]; // Ready the cycle after req_en.
            end
        end
    end

endmodule

/* spi/spi_iff.sv */
`timescale 1ns/1ns

module spi_iff #(
    parameter int MOSI_SIZE = 48,
    parameter int MISO_SIZE = 48
) (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 spi_clk,
    input  logic                 spi_ss,
    input  logic                 spi_mosi,
    output logic                 spi_miso,
    output logic [MOSI_SIZE-1:0] data_mosi,
    output logic [10:0]          data_len_bytes,
    input  logic [MISO_SIZE-1:0] data_miso,
    output logic                 valid
);

    logic [MOSI_SIZE-1:0] in_reg;
    logic [MISO_SIZE-1:0] out_reg;
    logic [13:0]          len_bits; // Bits received in the current frame.

    logic sync_mosi;
    logic sync_sck;
    logic sync_ss;
    logic last_sck;
    logic last_ss;

    logic sck_rise;
    logic sck_fall;
    logic ss_rise;
    logic ss_fall;

    sync_sig i_sync_mosi (
        .clk     (clk),
        .nrst    (nrst),
        .in_sig  (spi_mosi),
        .out_sig (sync_mosi)
    );

    sync_sig i_sync_sck (
        .clk     (clk),
        .nrst    (nrst),
        .in_sig  (spi_clk),
        .out_sig (sync_sck)
    );

    sync_sig i_sync_ss (
        .clk     (clk),
        .nrst    (nrst),
        .in_sig  (spi_ss),
        .out_sig (sync_ss)
    );

    // Previous samples for edge detection.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            last_sck <= 1'b0;
            last_ss  <= 1'b1; // SS idles high.
        end else begin
            last_sck <= sync_sck;
            last_ss  <= sync_ss;
        end
    end

    assign sck_rise = !last_sck && sync_sck;
    assign sck_fall = last_sck && !sync_sck;
    assign ss_rise  = !last_ss && sync_ss;
    assign ss_fall  = last_ss && !sync_ss;

    // MISO is driven low while deselected.
    assign spi_miso       = sync_ss ? 1'b0 : out_reg[MISO_SIZE-1];
    assign data_len_bytes = len_bits[13:3];

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            in_reg   <= '0;
            len_bits <= '0;
        end else if (ss_fall) begin
            in_reg   <= '0; // New frame starts empty.
            len_bits <= '0;
        end else if (sck_rise && !sync_ss) begin
            in_reg   <= {in_reg[MOSI_SIZE-2:0], sync_mosi};
            len_bits <= len_bits + 14'd1;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            out_reg <= '0;
        end else if (ss_fall) begin
            out_reg <= data_miso; // Reply of the previous frame.
        end else if (ss_rise) begin
            out_reg <= '0;
        end else if (sck_fall && !sync_ss) begin
            out_reg <= {out_reg[MISO_SIZE-2:0], 1'b0};
        end
    end

    // An SS pulse with no clocks (as seen right after reset) is not a frame.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            data_mosi <= '0;
            valid     <= 1'b0;
        end else begin
            valid <= 1'b0;
            if (ss_rise) begin
                data_mosi <= in_reg;
                valid     <= (len_bits[2:0] == 3'd0) && (len_bits != '0);
            end
        end
    end

endmodule

/* spi/sync_sig.sv */
`timescale 1ns/1ns

module sync_sig (
    input  logic clk,
    input  logic nrst,
    input  logic in_sig,
    output logic out_sig
);

    logic meta; // First stage, may go metastable.

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            meta    <= 1'b0;
            out_sig <= 1'b0;
        end else begin
            meta    <= in_sig;
            out_sig <= meta; // Settled copy of the pin.
        end
    end

endmodule

/* common/spi_regs_pkg.sv */
package spi_regs_pkg;

    // Request and reply length in bytes.
    localparam int unsigned FRAME_BYTES = 6;

    localparam logic [7:0] OP_WRITE  = 8'h01; // Write one register.
    localparam logic [7:0] OP_READ   = 8'h02; // Read one register.
    localparam logic [7:0] OP_STATUS = 8'h03; // Report accepted frame count.

    localparam int ST_OK       = 0; // Frame accepted.
    localparam int ST_LEN_ERR  = 1; // Frame was not FRAME_BYTES long.
    localparam int ST_OP_ERR   = 2; // Opcode not recognised.
    localparam int ST_ADDR_ERR = 3; // Register address out of range.

    // Request as received from the master. The opcode is shifted in first.
    typedef struct packed {
        logic [7:0]  opcode;
        logic [7:0]  addr;
        logic [31:0] data;
    } spi_frame_t;

    // Reply shifted out during the following frame with the status first.
    typedef struct packed {
        logic [7:0]  status;
        logic [7:0]  addr;
        logic [31:0] data;
    } spi_resp_t;

    // Single access to the register bank.
    typedef struct packed {
        logic        we;
        logic [7:0]  addr;
        logic [31:0] wdata;
    } reg_req_t;

endpackage
